//--- logic/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int rob_size = 8;
  localparam int rob_ix_w = 3;
  localparam int iq_size = 4;
  localparam int rs_size = 4;

  // csr offsets, decoded on the low address bits only
  localparam int csr_addr_w = 4;
  localparam logic [csr_addr_w-1:0] csr_ctrl_addr = 4'h0;
  localparam logic [csr_addr_w-1:0] csr_count_addr = 4'h4;
  localparam logic [csr_addr_w-1:0] csr_last_addr = 4'h8;

  typedef enum logic [3:0] {
    it_op,
    it_opimm,
    it_lui,
    it_nop,
    it_illegal
  } itype_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_lui
  } alu_func_t;

endpackage

`default_nettype wire

//--- logic/instruction_queue.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_queue (
  input wire clk_in,
  input wire rst,
  input wire instr_valid,
  input wire [ooo_pkg::xlen-1:0] instr,
  input wire inst_read,
  output logic instr_ready,
  output logic inst_available,
  output logic [ooo_pkg::xlen-1:0] inst_word
);

  logic [ooo_pkg::xlen-1:0] mem [ooo_pkg::iq_size];
  logic [$clog2(ooo_pkg::iq_size)-1:0] wr_ptr, rd_ptr;
  logic [$clog2(ooo_pkg::iq_size):0] count, count_next;
  logic push;

  assign push = instr_valid && instr_ready;
  assign inst_available = (count != 0);
  assign inst_word = mem[rd_ptr];

  always_comb begin
    count_next = count;
    if (push && !inst_read) count_next = count + 1'b1;
    else if (!push && inst_read) count_next = count - 1'b1;
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      instr_ready <= 1'b0; // low for the reset cycle only
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (inst_read) rd_ptr <= rd_ptr + 1'b1;
      count <= count_next;
      instr_ready <= (count_next != ooo_pkg::iq_size);
    end
  end

  always_ff @(posedge clk_in) begin
    if (push) mem[wr_ptr] <= instr;
  end

  // issue logic must only pop a word it has seen
  a_no_pop_empty: assert property (@(posedge clk_in) disable iff (rst)
    inst_read |-> inst_available);

endmodule

`default_nettype wire

//--- logic/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode (
  input wire [ooo_pkg::xlen-1:0] instruction,
  output ooo_pkg::itype_t itype,
  output ooo_pkg::alu_func_t alu_func,
  output logic [ooo_pkg::xlen-1:0] imm,
  output logic [ooo_pkg::reg_addr_w-1:0] rs1,
  output logic [ooo_pkg::reg_addr_w-1:0] rs2,
  output logic [ooo_pkg::reg_addr_w-1:0] rd
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic alt; // funct7 bit 5, selects sub and sra

  assign opcode = instruction[6:0];
  assign funct3 = instruction[14:12];
  assign alt = instruction[30];

  // shared funct3 map for op and op-imm
  function automatic ooo_pkg::alu_func_t f3_func(input logic [2:0] f3, input logic sub_ok,
                                                 input logic alt_bit);
    case (f3)
      3'b000: f3_func = (sub_ok && alt_bit) ? ooo_pkg::alu_sub : ooo_pkg::alu_add;
      3'b001: f3_func = ooo_pkg::alu_sll;
      3'b010: f3_func = ooo_pkg::alu_slt;
      3'b011: f3_func = ooo_pkg::alu_sltu;
      3'b100: f3_func = ooo_pkg::alu_xor;
      3'b101: f3_func = alt_bit ? ooo_pkg::alu_sra : ooo_pkg::alu_srl;
      3'b110: f3_func = ooo_pkg::alu_or;
      default: f3_func = ooo_pkg::alu_and;
    endcase
  endfunction

  always_comb begin
    itype = ooo_pkg::it_illegal;
    alu_func = ooo_pkg::alu_add;
    imm = '0;
    rs1 = instruction[19:15];
    rs2 = '0;
    rd = instruction[11:7];
    case (opcode)
      7'b0110011: begin
        itype = ooo_pkg::it_op;
        alu_func = f3_func(funct3, 1'b1, alt);
        rs2 = instruction[24:20];
      end
      7'b0010011: begin
        itype = ooo_pkg::it_opimm;
        alu_func = f3_func(funct3, 1'b0, alt);
        imm = {{20{instruction[31]}}, instruction[31:20]}; // i-type, sign extended
      end
      7'b0110111: begin
        itype = ooo_pkg::it_lui;
        alu_func = ooo_pkg::alu_lui;
        imm = {instruction[31:12], 12'b0};
        rs1 = '0; // field is immediate bits
      end
      default: begin
        if (instruction == '0) itype = ooo_pkg::it_nop;
        rd = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input wire clk_in,
  input wire rst,
  input wire [ooo_pkg::reg_addr_w-1:0] rs1,
  input wire [ooo_pkg::reg_addr_w-1:0] rs2,
  output logic [ooo_pkg::xlen-1:0] rd1,
  output logic [ooo_pkg::xlen-1:0] rd2,
  output logic tag1_valid,
  output logic [ooo_pkg::rob_ix_w-1:0] tag1,
  output logic tag2_valid,
  output logic [ooo_pkg::rob_ix_w-1:0] tag2,
  input wire rename_en,
  input wire [ooo_pkg::reg_addr_w-1:0] rename_rd,
  input wire [ooo_pkg::rob_ix_w-1:0] rename_ix,
  input wire commit_valid,
  input wire [ooo_pkg::reg_addr_w-1:0] commit_rd,
  input wire [ooo_pkg::rob_ix_w-1:0] commit_ix,
  input wire [ooo_pkg::xlen-1:0] commit_value
);

  logic [ooo_pkg::xlen-1:0] regs [32];
  logic [ooo_pkg::rob_ix_w-1:0] tags [32];
  logic [31:0] tag_valid;

  // x0 never gets a tag, so only the value needs forcing
  assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == '0) ? '0 : regs[rs2];
  assign tag1_valid = tag_valid[rs1];
  assign tag1 = tags[rs1];
  assign tag2_valid = tag_valid[rs2];
  assign tag2 = tags[rs2];

  always_ff @(posedge clk_in) begin
    if (rst) begin
      tag_valid <= '0;
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else begin
      if (commit_valid && commit_rd != '0) begin
        regs[commit_rd] <= commit_value;
        // younger writer still pending, keep its tag
        if (tags[commit_rd] == commit_ix) tag_valid[commit_rd] <= 1'b0;
      end
      if (rename_en && rename_rd != '0) tag_valid[rename_rd] <= 1'b1; // rename wins
    end
  end

  always_ff @(posedge clk_in) begin
    if (rename_en && rename_rd != '0) tags[rename_rd] <= rename_ix;
  end

endmodule

`default_nettype wire

//--- logic/rob.sv
`timescale 1ns/1ps
`default_nettype none

module rob (
  input wire clk_in,
  input wire rst,
  input wire alloc_en,
  input wire [ooo_pkg::reg_addr_w-1:0] alloc_rd,
  output logic [ooo_pkg::rob_ix_w-1:0] alloc_ix,
  output logic rob_ready,
  input wire [ooo_pkg::rob_ix_w-1:0] fwd_ix1,
  input wire [ooo_pkg::rob_ix_w-1:0] fwd_ix2,
  output logic fwd_done1,
  output logic fwd_done2,
  output logic [ooo_pkg::xlen-1:0] fwd_value1,
  output logic [ooo_pkg::xlen-1:0] fwd_value2,
  input wire cdb_valid,
  input wire [ooo_pkg::rob_ix_w-1:0] cdb_ix,
  input wire [ooo_pkg::xlen-1:0] cdb_value,
  output logic commit_valid,
  output logic [ooo_pkg::reg_addr_w-1:0] commit_rd,
  output logic [ooo_pkg::rob_ix_w-1:0] commit_ix,
  output logic [ooo_pkg::xlen-1:0] commit_value
);

  logic [ooo_pkg::reg_addr_w-1:0] ent_rd [ooo_pkg::rob_size];
  logic [ooo_pkg::xlen-1:0] ent_value [ooo_pkg::rob_size];
  logic [ooo_pkg::rob_size-1:0] ent_done;
  logic [ooo_pkg::rob_ix_w-1:0] head, tail;
  logic [$clog2(ooo_pkg::rob_size):0] count;
  logic [ooo_pkg::rob_ix_w-1:0] cdb_off; // distance of bus tag from head

  assign alloc_ix = tail;
  assign rob_ready = (count != ooo_pkg::rob_size);

  assign fwd_done1 = ent_done[fwd_ix1];
  assign fwd_done2 = ent_done[fwd_ix2];
  assign fwd_value1 = ent_value[fwd_ix1];
  assign fwd_value2 = ent_value[fwd_ix2];

  // in-order retire from the head
  assign commit_valid = (count != 0) && ent_done[head];
  assign commit_rd = ent_rd[head];
  assign commit_ix = head;
  assign commit_value = ent_value[head];

  assign cdb_off = cdb_ix - head;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      ent_done <= '0;
    end else begin
      if (cdb_valid) ent_done[cdb_ix] <= 1'b1;
      if (alloc_en) begin
        ent_done[tail] <= 1'b0;
        tail <= tail + 1'b1;
      end
      if (commit_valid) head <= head + 1'b1;
      case ({alloc_en, commit_valid})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (alloc_en) ent_rd[tail] <= alloc_rd;
    if (cdb_valid) ent_value[cdb_ix] <= cdb_value;
  end

  a_no_alloc_full: assert property (@(posedge clk_in) disable iff (rst)
    alloc_en |-> rob_ready);

  // a result may only land on a live entry between head and tail
  a_cdb_allocated: assert property (@(posedge clk_in) disable iff (rst)
    cdb_valid |-> ({1'b0, cdb_off} < count));

endmodule

`default_nettype wire

//--- logic/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station (
  input wire clk_in,
  input wire rst,
  input wire insert_en,
  input ooo_pkg::alu_func_t insert_func,
  input wire [ooo_pkg::rob_ix_w-1:0] insert_ix,
  input wire op1_ready,
  input wire [ooo_pkg::rob_ix_w-1:0] op1_tag,
  input wire [ooo_pkg::xlen-1:0] op1_value,
  input wire op2_ready,
  input wire [ooo_pkg::rob_ix_w-1:0] op2_tag,
  input wire [ooo_pkg::xlen-1:0] op2_value,
  output logic rs_ready,
  input wire cdb_valid,
  input wire [ooo_pkg::rob_ix_w-1:0] cdb_ix,
  input wire [ooo_pkg::xlen-1:0] cdb_value,
  output logic disp_valid,
  output ooo_pkg::alu_func_t disp_func,
  output logic [ooo_pkg::xlen-1:0] disp_a,
  output logic [ooo_pkg::xlen-1:0] disp_b,
  output logic [ooo_pkg::rob_ix_w-1:0] disp_ix
);

  logic [ooo_pkg::rs_size-1:0] busy, r1, r2;
  ooo_pkg::alu_func_t func [ooo_pkg::rs_size];
  logic [ooo_pkg::rob_ix_w-1:0] ix [ooo_pkg::rs_size];
  logic [ooo_pkg::rob_ix_w-1:0] t1 [ooo_pkg::rs_size];
  logic [ooo_pkg::rob_ix_w-1:0] t2 [ooo_pkg::rs_size];
  logic [ooo_pkg::xlen-1:0] v1 [ooo_pkg::rs_size];
  logic [ooo_pkg::xlen-1:0] v2 [ooo_pkg::rs_size];
  logic [$clog2(ooo_pkg::rs_size)-1:0] free_sel, disp_sel;
  logic free_found, disp_found;

  // downward scan leaves the lowest match selected
  always_comb begin
    free_found = 1'b0;
    free_sel = '0;
    disp_found = 1'b0;
    disp_sel = '0;
    for (int i = ooo_pkg::rs_size - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        free_found = 1'b1;
        free_sel = i[$clog2(ooo_pkg::rs_size)-1:0];
      end
      if (busy[i] && r1[i] && r2[i]) begin
        disp_found = 1'b1;
        disp_sel = i[$clog2(ooo_pkg::rs_size)-1:0];
      end
    end
  end

  assign rs_ready = free_found;
  assign disp_valid = disp_found;
  assign disp_func = func[disp_sel];
  assign disp_a = v1[disp_sel];
  assign disp_b = v2[disp_sel];
  assign disp_ix = ix[disp_sel];

  always_ff @(posedge clk_in) begin
    if (rst) begin
      busy <= '0;
    end else begin
      if (disp_found) busy[disp_sel] <= 1'b0;
      if (insert_en) busy[free_sel] <= 1'b1; // never the slot being freed
    end
  end

  always_ff @(posedge clk_in) begin
    for (int i = 0; i < ooo_pkg::rs_size; i++) begin
      if (cdb_valid && busy[i] && !r1[i] && t1[i] == cdb_ix) begin // operand wakeup
        r1[i] <= 1'b1;
        v1[i] <= cdb_value;
      end
      if (cdb_valid && busy[i] && !r2[i] && t2[i] == cdb_ix) begin
        r2[i] <= 1'b1;
        v2[i] <= cdb_value;
      end
    end
    if (insert_en) begin
      func[free_sel] <= insert_func;
      ix[free_sel] <= insert_ix;
      r1[free_sel] <= op1_ready;
      t1[free_sel] <= op1_tag;
      v1[free_sel] <= op1_value;
      r2[free_sel] <= op2_ready;
      t2[free_sel] <= op2_tag;
      v2[free_sel] <= op2_value;
    end
  end

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input wire clk_in,
  input wire rst,
  input wire disp_valid,
  input ooo_pkg::alu_func_t disp_func,
  input wire [ooo_pkg::xlen-1:0] disp_a,
  input wire [ooo_pkg::xlen-1:0] disp_b,
  input wire [ooo_pkg::rob_ix_w-1:0] disp_ix,
  output logic cdb_valid,
  output logic [ooo_pkg::rob_ix_w-1:0] cdb_ix,
  output logic [ooo_pkg::xlen-1:0] cdb_value
);

  logic [ooo_pkg::xlen-1:0] result;
  logic [4:0] shamt;

  assign shamt = disp_b[4:0];

  always_comb begin
    case (disp_func)
      ooo_pkg::alu_sub: result = disp_a - disp_b;
      ooo_pkg::alu_sll: result = disp_a << shamt;
      ooo_pkg::alu_slt: result = {31'b0, $signed(disp_a) < $signed(disp_b)};
      ooo_pkg::alu_sltu: result = {31'b0, disp_a < disp_b};
      ooo_pkg::alu_xor: result = disp_a ^ disp_b;
      ooo_pkg::alu_srl: result = disp_a >> shamt;
      ooo_pkg::alu_sra: result = $unsigned($signed(disp_a) >>> shamt);
      ooo_pkg::alu_or: result = disp_a | disp_b;
      ooo_pkg::alu_and: result = disp_a & disp_b;
      ooo_pkg::alu_lui: result = disp_b; // immediate already shifted by decode
      default: result = disp_a + disp_b;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst) cdb_valid <= 1'b0;
    else cdb_valid <= disp_valid;
  end

  always_ff @(posedge clk_in) begin
    cdb_ix <= disp_ix;
    cdb_value <= result;
  end

endmodule

`default_nettype wire

//--- logic/ooo_csr.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_csr (
  input wire clk_in,
  input wire rst,
  input wire awvalid,
  output logic awready,
  input wire [ooo_pkg::csr_addr_w-1:0] awaddr,
  input wire wvalid,
  output logic wready,
  input wire [ooo_pkg::xlen-1:0] wdata,
  input wire [ooo_pkg::xlen/8-1:0] wstrb,
  output logic bvalid,
  input wire bready,
  output logic [1:0] bresp,
  input wire arvalid,
  output logic arready,
  input wire [ooo_pkg::csr_addr_w-1:0] araddr,
  output logic rvalid,
  input wire rready,
  output logic [ooo_pkg::xlen-1:0] rdata,
  output logic [1:0] rresp,
  input wire commit_valid,
  input wire [ooo_pkg::xlen-1:0] commit_value,
  output logic issue_en
);

  logic wr_go, rd_go;
  logic [ooo_pkg::xlen-1:0] commit_count, last_value;

  // aw and w taken together, one write in flight
  assign awready = awvalid && wvalid && !bvalid;
  assign wready = awready;
  assign wr_go = awready;
  assign arready = !rvalid;
  assign rd_go = arvalid && arready;
  assign bresp = 2'b00; // always okay
  assign rresp = 2'b00;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
      issue_en <= 1'b1;
      commit_count <= '0;
      last_value <= '0;
    end else begin
      if (wr_go) bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
      if (rd_go) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
      if (wr_go && awaddr == ooo_pkg::csr_ctrl_addr && wstrb[0]) issue_en <= wdata[0];
      if (wr_go && awaddr == ooo_pkg::csr_count_addr) commit_count <= '0; // any data clears
      else if (commit_valid) commit_count <= commit_count + 1'b1;
      if (commit_valid) last_value <= commit_value;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rd_go) begin
      case (araddr)
        ooo_pkg::csr_ctrl_addr: rdata <= {{(ooo_pkg::xlen-1){1'b0}}, issue_en};
        ooo_pkg::csr_count_addr: rdata <= commit_count;
        ooo_pkg::csr_last_addr: rdata <= last_value;
        default: rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core (
  input wire clk_in,
  input wire rst,
  input wire instr_valid,
  input wire [ooo_pkg::xlen-1:0] instr,
  output logic instr_ready,
  output logic commit_valid,
  output logic [ooo_pkg::reg_addr_w-1:0] commit_rd,
  output logic [ooo_pkg::xlen-1:0] commit_value,
  input wire awvalid,
  output logic awready,
  input wire [ooo_pkg::csr_addr_w-1:0] awaddr,
  input wire wvalid,
  output logic wready,
  input wire [ooo_pkg::xlen-1:0] wdata,
  input wire [ooo_pkg::xlen/8-1:0] wstrb,
  output logic bvalid,
  input wire bready,
  output logic [1:0] bresp,
  input wire arvalid,
  output logic arready,
  input wire [ooo_pkg::csr_addr_w-1:0] araddr,
  output logic rvalid,
  input wire rready,
  output logic [ooo_pkg::xlen-1:0] rdata,
  output logic [1:0] rresp
);

  logic inst_available, inst_read;
  logic [ooo_pkg::xlen-1:0] inst_word;
  ooo_pkg::itype_t itype;
  ooo_pkg::alu_func_t alu_func, disp_func;
  logic [ooo_pkg::xlen-1:0] imm, rd1, rd2, fwd_value1, fwd_value2;
  logic [ooo_pkg::reg_addr_w-1:0] rs1, rs2, rd;
  logic tag1_valid, tag2_valid, fwd_done1, fwd_done2;
  logic [ooo_pkg::rob_ix_w-1:0] tag1, tag2, alloc_ix, commit_ix, disp_ix, cdb_ix;
  logic rob_ready, rs_ready, issue_en, is_alu, issue_go, use_imm;
  logic op1_ready, op2_ready, disp_valid, cdb_valid;
  logic [ooo_pkg::xlen-1:0] op1_value, op2_value, disp_a, disp_b, cdb_value;

  // nop and illegal words are popped without a rob slot
  assign is_alu = (itype == ooo_pkg::it_op) || (itype == ooo_pkg::it_opimm) ||
                  (itype == ooo_pkg::it_lui);
  assign use_imm = (itype == ooo_pkg::it_opimm) || (itype == ooo_pkg::it_lui);
  assign issue_go = inst_available && issue_en && is_alu && rob_ready && rs_ready;
  assign inst_read = inst_available && issue_en && (!is_alu || (rob_ready && rs_ready));

  // operand source: register, then finished rob entry, then the bus this cycle
  assign op1_ready = !tag1_valid || fwd_done1 || (cdb_valid && cdb_ix == tag1);
  assign op1_value = !tag1_valid ? rd1 : (fwd_done1 ? fwd_value1 : cdb_value);
  assign op2_ready = use_imm || !tag2_valid || fwd_done2 || (cdb_valid && cdb_ix == tag2);
  assign op2_value = use_imm ? imm :
                     (!tag2_valid ? rd2 : (fwd_done2 ? fwd_value2 : cdb_value));

  instruction_queue iq_i (
    .clk_in(clk_in), .rst(rst), .instr_valid(instr_valid), .instr(instr),
    .inst_read(inst_read), .instr_ready(instr_ready),
    .inst_available(inst_available), .inst_word(inst_word)
  );

  decode decode_i (
    .instruction(inst_word), .itype(itype), .alu_func(alu_func), .imm(imm),
    .rs1(rs1), .rs2(rs2), .rd(rd)
  );

  register_file rf_i (
    .clk_in(clk_in), .rst(rst), .rs1(rs1), .rs2(rs2), .rd1(rd1), .rd2(rd2),
    .tag1_valid(tag1_valid), .tag1(tag1), .tag2_valid(tag2_valid), .tag2(tag2),
    .rename_en(issue_go && rd != '0), .rename_rd(rd), .rename_ix(alloc_ix),
    .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_ix(commit_ix),
    .commit_value(commit_value)
  );

  rob rob_i (
    .clk_in(clk_in), .rst(rst), .alloc_en(issue_go), .alloc_rd(rd),
    .alloc_ix(alloc_ix), .rob_ready(rob_ready), .fwd_ix1(tag1), .fwd_ix2(tag2),
    .fwd_done1(fwd_done1), .fwd_done2(fwd_done2),
    .fwd_value1(fwd_value1), .fwd_value2(fwd_value2),
    .cdb_valid(cdb_valid), .cdb_ix(cdb_ix), .cdb_value(cdb_value),
    .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_ix(commit_ix),
    .commit_value(commit_value)
  );

  reservation_station rs_i (
    .clk_in(clk_in), .rst(rst), .insert_en(issue_go), .insert_func(alu_func),
    .insert_ix(alloc_ix), .op1_ready(op1_ready), .op1_tag(tag1), .op1_value(op1_value),
    .op2_ready(op2_ready), .op2_tag(tag2), .op2_value(op2_value), .rs_ready(rs_ready),
    .cdb_valid(cdb_valid), .cdb_ix(cdb_ix), .cdb_value(cdb_value),
    .disp_valid(disp_valid), .disp_func(disp_func), .disp_a(disp_a), .disp_b(disp_b),
    .disp_ix(disp_ix)
  );

  alu alu_i (
    .clk_in(clk_in), .rst(rst), .disp_valid(disp_valid), .disp_func(disp_func),
    .disp_a(disp_a), .disp_b(disp_b), .disp_ix(disp_ix),
    .cdb_valid(cdb_valid), .cdb_ix(cdb_ix), .cdb_value(cdb_value)
  );

  ooo_csr csr_i (
    .clk_in(clk_in), .rst(rst),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
    .commit_valid(commit_valid), .commit_value(commit_value), .issue_en(issue_en)
  );

endmodule

`default_nettype wire

//--- sim/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic clk_in
);

  localparam realtime half_period = 4.0; // 8 ns period

  initial clk_in = 1'b0;

  always #(half_period) clk_in = ~clk_in;

endmodule

`default_nettype wire

//--- sim/ooo_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb;

  localparam int n_alu = 60; // alu words per program
  localparam int n_prog = 3;
  localparam int axi_ops = 12;
  localparam int drain_cycles = 24;
  localparam int hold_cycles = 32;
  localparam int watchdog_cycles = n_prog * 2 * n_alu * 40 + axi_ops * 20 + 200;

  logic clk_in, rst, instr_valid, instr_ready, commit_valid;
  logic [31:0] instr, commit_value, wdata, rdata;
  logic [4:0] commit_rd;
  logic awvalid, awready, wvalid, wready, bvalid, bready, arvalid, arready, rvalid, rready;
  logic [ooo_pkg::csr_addr_w-1:0] awaddr, araddr;
  logic [3:0] wstrb;
  logic [1:0] bresp, rresp;

  logic [31:0] rng, rd_expect, last_model;
  logic [31:0] model_x [32];
  logic [31:0] prog [$];
  logic [36:0] exp_q [$]; // {rd, value} in program order
  logic exp_any = 1'b0;
  logic [4:0] exp_rd = '0;
  logic [31:0] exp_value = '0;
  logic accepted_any = 1'b0;
  logic hold_check = 1'b0;
  int model_total = 0;
  int csr_count_model = 0;
  int commit_seen = 0;
  int errors = 0;

  clk_gen clk_gen_i (.clk_in(clk_in));

  ooo_core ooo_core_i (
    .clk_in(clk_in), .rst(rst), .instr_valid(instr_valid), .instr(instr),
    .instr_ready(instr_ready), .commit_valid(commit_valid), .commit_rd(commit_rd),
    .commit_value(commit_value),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
  );

  task automatic stop_run();
    errors++;
    $display("Checks failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic show_mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic abort_with(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    stop_run();
  endtask

  a_commit_expected: assert property (@(posedge clk_in) disable iff (rst)
    commit_valid |-> exp_any)
    else abort_with("commit arrived with no expected result pending");

  a_commit_rd: assert property (@(posedge clk_in) disable iff (rst)
    commit_valid && exp_any |-> commit_rd == exp_rd)
    else show_mismatch($sformatf("commit_rd %0d, expected %0d",
                                 $sampled(commit_rd), $sampled(exp_rd)));

  a_commit_value: assert property (@(posedge clk_in) disable iff (rst)
    commit_valid && exp_any |-> commit_value == exp_value)
    else show_mismatch($sformatf("commit_value %h, expected %h",
                                 $sampled(commit_value), $sampled(exp_value)));

  a_ready_after_reset: assert property (@(posedge clk_in) $fell(rst) |=> instr_ready)
    else abort_with("instr_ready did not rise after reset");

  a_quiet_before_accept: assert property (@(posedge clk_in) disable iff (rst)
    !accepted_any |-> !commit_valid)
    else abort_with("commit_valid rose before any instruction was accepted");

  a_hold_idle: assert property (@(posedge clk_in) disable iff (rst)
    hold_check |-> !commit_valid && !instr_ready)
    else abort_with("core committed or took words while issue was disabled");

  a_bresp_okay: assert property (@(posedge clk_in) bvalid && bready |-> bresp == 2'b00)
    else show_mismatch($sformatf("bresp %0d, expected OKAY", $sampled(bresp)));

  a_rresp_okay: assert property (@(posedge clk_in) rvalid && rready |-> rresp == 2'b00)
    else show_mismatch($sformatf("rresp %0d, expected OKAY", $sampled(rresp)));

  a_rdata: assert property (@(posedge clk_in) rvalid && rready |-> rdata == rd_expect)
    else show_mismatch($sformatf("rdata %h, expected %h",
                                 $sampled(rdata), $sampled(rd_expect)));

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic logic [31:0] make_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
    logic [31:0] r;
    logic [2:0] f3;
    logic alt;
    logic [11:0] imm12;
    r = next_rand();
    f3 = r[10:8];
    alt = r[11] && (f3 == 3'd0 || f3 == 3'd5); // sub and sra only
    imm12 = r[31:20];
    if (r[2:0] == 3'd7) return {r[31:12], rd, 7'b0110111};
    if (r[2:0] < 3'd4) return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    if (f3 == 3'd1) imm12 = {7'b0, r[24:20]};
    else if (f3 == 3'd5) imm12 = {1'b0, alt, 5'b0, r[24:20]}; // srli / srai
    return {imm12, rs1, f3, rd, 7'b0010011};
  endfunction

  // in-order rv32i model, one expected commit per non-nop word
  task automatic model_step(input logic [31:0] w);
    logic [31:0] a, b, v;
    logic [4:0] rd;
    rd = w[11:7];
    a = model_x[w[19:15]];
    b = (w[6:0] == 7'b0010011) ? {{20{w[31]}}, w[31:20]} : model_x[w[24:20]];
    case (w[14:12])
      3'd0: v = (w[6:0] == 7'b0110011 && w[30]) ? a - b : a + b;
      3'd1: v = a << b[4:0];
      3'd2: v = {31'b0, $signed(a) < $signed(b)};
      3'd3: v = {31'b0, a < b};
      3'd4: v = a ^ b;
      3'd5: v = w[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: v = a | b;
      default: v = a & b;
    endcase
    if (w[6:0] == 7'b0110111) v = {w[31:12], 12'h000};
    exp_q.push_back({rd, v});
    if (rd != 5'd0) model_x[rd] = v; // x0 commits but is never written
    model_total++;
    csr_count_model++;
    last_model = v;
  endtask

  task automatic add_word(input logic [31:0] w);
    prog.push_back(w);
    if (w != 32'h0) model_step(w);
  endtask

  task automatic load_expected_head();
    exp_any = (exp_q.size() != 0);
    {exp_rd, exp_value} = exp_any ? exp_q[0] : '0;
  endtask

  // chain mode makes every word read the rd of the one before
  task automatic gen_program(input bit chain);
    logic [31:0] r;
    logic [4:0] rd, rs1, rs2, prev;
    prog.delete();
    prev = 5'd1;
    for (int i = 0; i < n_alu; i++) begin
      r = next_rand();
      if (r[2:0] == 3'd0) add_word(32'h0);
      rd = {2'b0, r[10:8]};
      rs1 = {2'b0, r[13:11]};
      rs2 = {2'b0, r[16:14]};
      if (chain) begin
        if (rd == 5'd0) rd = 5'd7;
        rs1 = prev;
        if (r[17]) rs2 = prev;
        prev = rd;
      end
      add_word(make_word(rd, rs1, rs2));
    end
    load_expected_head();
  endtask

  task automatic send_word(input logic [31:0] w);
    logic taken;
    instr_valid = 1'b1;
    instr = w;
    do begin
      @(posedge clk_in);
      taken = instr_ready;
      #1;
    end while (!taken);
  endtask

  task automatic feed_range(input int lo, input int hi);
    for (int i = lo; i < hi; i++) send_word(prog[i]);
    instr_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk_in);
      #1;
    end
    repeat (4) @(posedge clk_in); // room for a stray extra commit
    #1;
    assert (commit_seen == model_total)
      else show_mismatch($sformatf("%0d commits, expected %0d", commit_seen, model_total));
  endtask

  task automatic axi_write(input logic [ooo_pkg::csr_addr_w-1:0] addr, input logic [31:0] data);
    logic taken;
    awvalid = 1'b1;
    wvalid = 1'b1;
    awaddr = addr;
    wdata = data;
    wstrb = 4'hf;
    bready = 1'b1;
    do begin
      @(posedge clk_in);
      taken = awready && wready;
      #1;
    end while (!taken);
    awvalid = 1'b0;
    wvalid = 1'b0;
    do begin
      @(posedge clk_in);
      taken = bvalid;
      #1;
    end while (!taken);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [ooo_pkg::csr_addr_w-1:0] addr,
                          input logic [31:0] expected);
    logic taken;
    rd_expect = expected;
    arvalid = 1'b1;
    araddr = addr;
    rready = 1'b1;
    do begin
      @(posedge clk_in);
      taken = arready;
      #1;
    end while (!taken);
    arvalid = 1'b0;
    do begin
      @(posedge clk_in);
      taken = rvalid;
      #1;
    end while (!taken);
    rready = 1'b0;
  endtask

  always @(posedge clk_in) begin
    if (!rst && commit_valid) begin
      commit_seen++;
      if (exp_q.size() != 0) void'(exp_q.pop_front());
      load_expected_head(); // assertions already sampled the old head
    end
  end

  always @(posedge clk_in) begin
    if (!rst && instr_valid && instr_ready) accepted_any <= 1'b1;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk_in);
    abort_with("timeout, commits stopped before the expected results drained");
  end

  initial begin
    rst = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    rd_expect = '0;
    last_model = '0;
    rng = 32'd24277;
    foreach (model_x[i]) model_x[i] = '0;
    repeat (8) @(posedge clk_in);
    #1 rst = 1'b0;

    // random program, then counter and last value over axi
    gen_program(1'b0);
    feed_range(0, prog.size());
    wait_drained();
    axi_read(ooo_pkg::csr_count_addr, csr_count_model);
    axi_read(ooo_pkg::csr_last_addr, last_model);
    axi_write(ooo_pkg::csr_count_addr, 32'h5a5a_0001);
    csr_count_model = 0;
    axi_read(ooo_pkg::csr_count_addr, 32'h0);

    // dependent chain
    gen_program(1'b1);
    feed_range(0, prog.size());
    wait_drained();

    // issue disabled mid-stream with instr_valid held high
    gen_program(1'b0);
    feed_range(0, 16);
    axi_write(ooo_pkg::csr_ctrl_addr, 32'h0);
    axi_read(ooo_pkg::csr_ctrl_addr, 32'h0);
    fork
      feed_range(16, prog.size());
      begin
        do @(posedge clk_in); while (instr_ready); // queue full
        #1;
        repeat (drain_cycles) @(posedge clk_in);
        #1 hold_check = 1'b1;
        repeat (hold_cycles) @(posedge clk_in);
        #1 hold_check = 1'b0;
        axi_write(ooo_pkg::csr_ctrl_addr, 32'h1);
      end
    join
    wait_drained();
    axi_read(ooo_pkg::csr_count_addr, csr_count_model);
    axi_read(ooo_pkg::csr_last_addr, last_model);

    if (errors == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      stop_run();
    end
  end

endmodule

`default_nettype wire

//--- ooo_core.f
logic/ooo_pkg.sv
logic/instruction_queue.sv
logic/decode.sv
logic/register_file.sv
logic/rob.sv
logic/reservation_station.sv
logic/alu.sv
logic/ooo_csr.sv
logic/ooo_core.sv
sim/clk_gen.sv
sim/ooo_core_tb.sv

//--- Bender.yml
package:
  name: ooo_core

sources:
  - logic/ooo_pkg.sv
  - logic/instruction_queue.sv
  - logic/decode.sv
  - logic/register_file.sv
  - logic/rob.sv
  - logic/reservation_station.sv
  - logic/alu.sv
  - logic/ooo_csr.sv
  - logic/ooo_core.sv
  - target: test
    files:
      - sim/clk_gen.sv
      - sim/ooo_core_tb.sv
